// File: logic/switch_cfg_pkg.sv
package switch_cfg_pkg;

    ////////////////////
    // Types
    typedef logic [6:0]   reg_addr_t;
    typedef logic [15:0]  reg_data_t;
    typedef logic [11:0]  hash_t;
    typedef logic [31:0]  flow_key_t;
    typedef logic [1:0]   port_id_t;
    typedef logic [2:0]   flow_idx_t;
    typedef logic [127:0] flow_table_t;

    typedef struct packed {
        hash_t     hash;
        flow_idx_t idx;
        port_id_t  port;
        logic      drop;
    } cls_result_t;

    ////////////////////
    // Register map
    localparam int N_PORTS = 4;
    localparam int N_FLOWS = 8;
    localparam int PORT_STRIDE = 3;

    localparam reg_addr_t SPI_POINTER_ADDR = 7'h00;
    localparam reg_addr_t TABLE_MODER_ADDR = 7'h01;
    localparam reg_addr_t TABLE_CTRL_ADDR  = 7'h02;
    localparam reg_addr_t TABLE_HASH_ADDR  = 7'h03;
    localparam reg_addr_t PORT_RX_BASE     = 7'h10;
    localparam reg_addr_t PORT_TX_BASE     = 7'h11;
    localparam reg_addr_t PORT_ER_BASE     = 7'h12;
    localparam reg_addr_t TABLE_ST_BASE    = 7'h30;

    // Port n resets to base + n * step
    localparam reg_data_t PORT_RX_RST   = 16'h5040;
    localparam reg_data_t PORT_TX_RST   = 16'hd0c0;
    localparam reg_data_t PORT_ER_RST   = 16'hf0e0;
    localparam reg_data_t PORT_RST_STEP = 16'h0101;

    localparam int CTRL_UPDATE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;
    localparam int ENTRY_PORT_LSB  = 0;
    localparam int ENTRY_EN_BIT    = 15;

endpackage

// File: logic/register_table.sv
`timescale 1ns/1ps

module register_table (
    input  logic                        clk,
    input  logic                        rst,
    input  switch_cfg_pkg::reg_addr_t   bus_addr,
    input  logic                        bus_wr,
    input  switch_cfg_pkg::reg_data_t   bus_din,
    input  switch_cfg_pkg::reg_addr_t   bus_raddr,
    output switch_cfg_pkg::reg_data_t   bus_dout,
    output switch_cfg_pkg::reg_data_t   spi_word,
    output logic                        update_en,
    output logic                        clear_cnt,
    output switch_cfg_pkg::hash_t       hash_seed,
    output switch_cfg_pkg::flow_table_t flow_table
);
    import switch_cfg_pkg::*;

    // Slot layout: 4 table regs, 3 per port, then flow entries
    localparam int PTR_SLOT  = 0;
    localparam int CTRL_SLOT = 2;
    localparam int HASH_SLOT = 3;
    localparam int PORT_SLOT = 4;
    localparam int FLOW_SLOT = PORT_SLOT + PORT_STRIDE * N_PORTS;
    localparam int NUM_REGS  = FLOW_SLOT + N_FLOWS;

    function automatic reg_addr_t slot_addr(int i);
        reg_addr_t base;
        int n;
        n = (i - PORT_SLOT) / PORT_STRIDE;
        case ((i - PORT_SLOT) % PORT_STRIDE)
            0: base = PORT_RX_BASE;
            1: base = PORT_TX_BASE;
            default: base = PORT_ER_BASE;
        endcase
        if (i >= FLOW_SLOT) return TABLE_ST_BASE + reg_addr_t'(i - FLOW_SLOT);
        if (i >= PORT_SLOT) return base + reg_addr_t'(PORT_STRIDE * n);
        case (i)
            0: return SPI_POINTER_ADDR;
            1: return TABLE_MODER_ADDR;
            2: return TABLE_CTRL_ADDR;
            default: return TABLE_HASH_ADDR;
        endcase
    endfunction

    function automatic reg_data_t slot_reset(int i);
        reg_data_t base;
        int n;
        n = (i - PORT_SLOT) / PORT_STRIDE;
        case ((i - PORT_SLOT) % PORT_STRIDE)
            0: base = PORT_RX_RST;
            1: base = PORT_TX_RST;
            default: base = PORT_ER_RST;
        endcase
        if (i < PORT_SLOT || i >= FLOW_SLOT) return '0;
        return base + reg_data_t'(n) * PORT_RST_STEP;
    endfunction

    reg_data_t [NUM_REGS-1:0] reg_q;
    logic [NUM_REGS-1:0]      rd_hit;
    logic [NUM_REGS-1:0]      spi_hit;
    reg_addr_t                spi_ptr;

    ////////////////////
    // Storage
    for (genvar g = 0; g < NUM_REGS; g++) begin : g_reg
        localparam reg_addr_t ADDR    = slot_addr(g);
        localparam reg_data_t RST_VAL = slot_reset(g);
        reg_data_t q;

        always_ff @(posedge clk) begin
            if (!rst) begin
                q <= RST_VAL;
            end else if (bus_wr && bus_addr == ADDR) begin
                q <= bus_din;
            end
        end

        assign reg_q[g]   = q;
        assign rd_hit[g]  = (bus_raddr == ADDR);
        assign spi_hit[g] = (spi_ptr == ADDR);
    end

    ////////////////////
    // Read ports
    always_comb begin
        bus_dout = '0;
        spi_word = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (rd_hit[i]) bus_dout = reg_q[i];
            if (spi_hit[i]) spi_word = reg_q[i];
        end
    end

    assign spi_ptr    = reg_addr_t'(reg_q[PTR_SLOT]);
    assign update_en  = reg_q[CTRL_SLOT][CTRL_UPDATE_BIT];
    assign clear_cnt  = reg_q[CTRL_SLOT][CTRL_CLEAR_BIT];
    assign hash_seed  = reg_q[HASH_SLOT][$bits(hash_t)-1:0];
    // Entry 0 lands in the low word
    assign flow_table = reg_q[FLOW_SLOT +: N_FLOWS];

    // Addresses outside the three map ranges
    a_unmapped_read_zero: assert property (
        @(posedge clk) disable iff (!rst)
            !(bus_raddr inside {[SPI_POINTER_ADDR : TABLE_HASH_ADDR],
                                [PORT_RX_BASE : PORT_RX_BASE + PORT_STRIDE * N_PORTS - 1],
                                [TABLE_ST_BASE : TABLE_ST_BASE + N_FLOWS - 1]})
            |-> (bus_dout == '0)
    );

endmodule

// File: logic/spi_readout.sv
`timescale 1ns/1ps

module spi_readout #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      spi_cs_n,
    input  logic                      spi_sclk,
    input  switch_cfg_pkg::reg_data_t spi_word,
    output logic                      spi_miso
);
    import switch_cfg_pkg::*;

    logic [SYNC_STAGES-1:0] cs_sync;
    logic [SYNC_STAGES-1:0] sclk_sync;
    logic                   cs_s;
    logic                   cs_d;
    logic                   sclk_s;
    logic                   sclk_d;
    logic                   cs_fall;
    logic                   shift_en;
    reg_data_t              shift_q;
    logic [3:0]             bit_cnt;
    logic                   done;

    ////////////////////
    // Synchronizers and edges
    always_ff @(posedge clk) begin
        if (!rst) begin
            cs_sync   <= '1;
            sclk_sync <= '0;
            cs_d      <= 1'b1;
            sclk_d    <= 1'b0;
        end else begin
            cs_sync   <= {cs_sync[SYNC_STAGES-2:0], spi_cs_n};
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], spi_sclk};
            cs_d      <= cs_s;
            sclk_d    <= sclk_s;
        end
    end

    assign cs_s     = cs_sync[SYNC_STAGES-1];
    assign sclk_s   = sclk_sync[SYNC_STAGES-1];
    assign cs_fall  = cs_d && !cs_s;
    // Mode 0 so the next bit goes out on the falling edge
    assign shift_en = sclk_d && !sclk_s && !cs_s && !done;

    ////////////////////
    // Bit counter
    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt <= '0;
            done    <= 1'b1;
        end else if (cs_fall) begin
            bit_cnt <= '0;
            done    <= 1'b0;
        end else if (shift_en) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd15) done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cs_fall) begin
            shift_q <= spi_word;
        end else if (shift_en) begin
            shift_q <= {shift_q[14:0], shift_q[15]};
        end
    end

    assign spi_miso = !cs_s && !done && shift_q[15];

    // Synchronized cs_n is the pin delayed by SYNC_STAGES clocks
    a_miso_idle: assert property (
        @(posedge clk) disable iff (!rst) $past(spi_cs_n, SYNC_STAGES) |-> !spi_miso
    );

endmodule

// File: logic/flow_classifier.sv
`timescale 1ns/1ps

module flow_classifier (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        update_en,
    input  logic                        clear_cnt,
    input  switch_cfg_pkg::hash_t       hash_seed,
    input  switch_cfg_pkg::flow_table_t flow_table,
    input  logic                        key_valid,
    input  switch_cfg_pkg::flow_key_t   key,
    output logic                        cls_valid,
    output switch_cfg_pkg::cls_result_t cls,
    output switch_cfg_pkg::reg_data_t   lookup_count
);
    import switch_cfg_pkg::*;

    reg_data_t [N_FLOWS-1:0] entries;
    hash_t                   hash;
    flow_idx_t               idx;
    reg_data_t               entry;

    ////////////////////
    // Hash and lookup
    assign hash    = key[11:0] ^ key[23:12] ^ hash_t'(key[31:24]) ^ hash_seed;
    assign idx     = hash[$bits(flow_idx_t)-1:0];
    assign entries = flow_table;
    assign entry   = entries[idx];

    always_ff @(posedge clk) begin
        if (!rst) begin
            cls_valid <= 1'b0;
        end else begin
            cls_valid <= key_valid && update_en;
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid) begin
            cls.hash <= hash;
            cls.idx  <= idx;
            cls.port <= entry[ENTRY_PORT_LSB +: $bits(port_id_t)];
            // Disabled entry drops the flow
            cls.drop <= !entry[ENTRY_EN_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst || clear_cnt) begin
            lookup_count <= '0;
        end else if (cls_valid) begin
            lookup_count <= lookup_count + 16'd1;
        end
    end

    a_valid_follows_key: assert property (
        @(posedge clk) disable iff (!rst) cls_valid |-> $past(key_valid && update_en)
    );

endmodule

// File: logic/switch_cfg_top.sv
`timescale 1ns/1ps

module switch_cfg_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                        clk,
    input  logic                        rst,
    input  switch_cfg_pkg::reg_addr_t   bus_addr,
    input  logic                        bus_wr,
    input  switch_cfg_pkg::reg_data_t   bus_din,
    input  switch_cfg_pkg::reg_addr_t   bus_raddr,
    output switch_cfg_pkg::reg_data_t   bus_dout,
    input  logic                        spi_cs_n,
    input  logic                        spi_sclk,
    output logic                        spi_miso,
    input  logic                        key_valid,
    input  switch_cfg_pkg::flow_key_t   key,
    output logic                        cls_valid,
    output switch_cfg_pkg::cls_result_t cls,
    output switch_cfg_pkg::reg_data_t   lookup_count
);
    import switch_cfg_pkg::*;

    reg_data_t   spi_word;
    logic        update_en;
    logic        clear_cnt;
    hash_t       hash_seed;
    flow_table_t flow_table;

    register_table register_table_inst (
        .clk        (clk),
        .rst        (rst),
        .bus_addr   (bus_addr),
        .bus_wr     (bus_wr),
        .bus_din    (bus_din),
        .bus_raddr  (bus_raddr),
        .bus_dout   (bus_dout),
        .spi_word   (spi_word),
        .update_en  (update_en),
        .clear_cnt  (clear_cnt),
        .hash_seed  (hash_seed),
        .flow_table (flow_table)
    );

    spi_readout #(
        .SYNC_STAGES (SYNC_STAGES)
    ) spi_readout_inst (
        .clk      (clk),
        .rst      (rst),
        .spi_cs_n (spi_cs_n),
        .spi_sclk (spi_sclk),
        .spi_word (spi_word),
        .spi_miso (spi_miso)
    );

    flow_classifier flow_classifier_inst (
        .clk          (clk),
        .rst          (rst),
        .update_en    (update_en),
        .clear_cnt    (clear_cnt),
        .hash_seed    (hash_seed),
        .flow_table   (flow_table),
        .key_valid    (key_valid),
        .key          (key),
        .cls_valid    (cls_valid),
        .cls          (cls),
        .lookup_count (lookup_count)
    );

endmodule

// File: tests/tb_switch_cfg.sv
`timescale 1ns/1ps

module tb_switch_cfg;
    import switch_cfg_pkg::*;

    localparam int SYNC_STAGES = 2;
    localparam int SPI_HALF = 4;
    // Tests take roughly 880 clk cycles
    localparam int WATCHDOG_CYCLES = 1000;

    logic        clk;
    logic        rst;
    reg_addr_t   bus_addr;
    logic        bus_wr;
    reg_data_t   bus_din;
    reg_addr_t   bus_raddr;
    reg_data_t   bus_dout;
    logic        spi_cs_n;
    logic        spi_sclk;
    logic        spi_miso;
    logic        key_valid;
    flow_key_t   key;
    logic        cls_valid;
    cls_result_t cls;
    reg_data_t   lookup_count;

    reg_data_t   exp_regs [0:127];
    logic        mapped [0:127];
    logic [31:0] rng_state = 32'h200b_e8c8;
    int          errors = 0;
    int          checks = 0;
    int          classified = 0;

    switch_cfg_top #(
        .SYNC_STAGES (SYNC_STAGES)
    ) switch_cfg_top_inst (
        .clk          (clk),
        .rst          (rst),
        .bus_addr     (bus_addr),
        .bus_wr       (bus_wr),
        .bus_din      (bus_din),
        .bus_raddr    (bus_raddr),
        .bus_dout     (bus_dout),
        .spi_cs_n     (spi_cs_n),
        .spi_sclk     (spi_sclk),
        .spi_miso     (spi_miso),
        .key_valid    (key_valid),
        .key          (key),
        .cls_valid    (cls_valid),
        .cls          (cls),
        .lookup_count (lookup_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Helpers
    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic compare_data(string name, reg_data_t exp, reg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_cls(string name, cls_result_t exp, cls_result_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Map and reset values, port n resets to 0x5n4n, 0xDnCn, 0xFnEn
    task automatic reset_model();
        for (int a = 0; a < 128; a++) begin
            exp_regs[a] = '0;
            mapped[a]   = (a < 4) || (a >= 'h10 && a < 'h1c) || (a >= 'h30 && a < 'h38);
        end
        for (int n = 0; n < 4; n++) begin
            exp_regs['h10 + 3 * n] = {4'h5, 4'(n), 4'h4, 4'(n)};
            exp_regs['h11 + 3 * n] = {4'hd, 4'(n), 4'hc, 4'(n)};
            exp_regs['h12 + 3 * n] = {4'hf, 4'(n), 4'he, 4'(n)};
        end
    endtask

    task automatic write_reg(reg_addr_t a, reg_data_t d);
        @(posedge clk);
        bus_addr <= a;
        bus_din  <= d;
        bus_wr   <= 1'b1;
        @(posedge clk);
        bus_wr <= 1'b0;
        if (mapped[a]) exp_regs[a] = d;
    endtask

    task automatic read_check(string name, reg_addr_t a);
        @(posedge clk);
        bus_raddr <= a;
        @(negedge clk);
        compare_data($sformatf("%s @%02h", name, a), exp_regs[a], bus_dout);
    endtask

    // Mode 0 master, miso sampled while sclk is high
    task automatic spi_read(input int nbits, output reg_data_t word);
        word = '0;
        @(negedge clk);
        compare_bit("spi idle miso", 1'b0, spi_miso);
        @(posedge clk);
        spi_cs_n <= 1'b0;
        repeat (SPI_HALF) @(posedge clk);
        for (int b = 0; b < nbits; b++) begin
            spi_sclk <= 1'b1;
            repeat (SPI_HALF - 1) @(posedge clk);
            @(negedge clk);
            word = {word[14:0], spi_miso};
            @(posedge clk);
            spi_sclk <= 1'b0;
            repeat (SPI_HALF) @(posedge clk);
        end
        spi_cs_n <= 1'b1;
        repeat (SYNC_STAGES + 1) @(posedge clk);
        @(negedge clk);
        compare_bit("spi miso after cs_n high", 1'b0, spi_miso);
    endtask

    function automatic cls_result_t expected_cls(flow_key_t k);
        cls_result_t r;
        reg_data_t   entry;
        r.hash = k[11:0] ^ k[23:12] ^ {4'h0, k[31:24]} ^ exp_regs[3][11:0];
        r.idx  = r.hash[2:0];
        entry  = exp_regs['h30 + int'(r.idx)];
        r.port = entry[1:0];
        r.drop = ~entry[15];
        return r;
    endfunction

    ////////////////////
    // Tests
    task automatic reset_values();
        for (int a = 0; a < 128; a++) read_check("reset value", reg_addr_t'(a));
    endtask

    task automatic write_readback();
        logic [31:0] r;
        reg_addr_t   a;
        for (int i = 0; i < 128; i++) begin
            if (mapped[i]) begin
                r = next_rand();
                write_reg(reg_addr_t'(i), r[15:0]);
            end
        end
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            a = r[6:0];
            while (mapped[a]) a = a + 7'd1;
            write_reg(a, r[31:16]);
        end
        for (int a2 = 0; a2 < 128; a2++) read_check("readback", reg_addr_t'(a2));
    endtask

    task automatic spi_pointer_reads();
        reg_addr_t   ptrs [3];
        reg_data_t   word;
        logic [31:0] r;
        ptrs = '{7'h13, 7'h35, 7'h03};
        foreach (ptrs[i]) begin
            r = next_rand();
            // Upper pointer bits must not matter
            write_reg(SPI_POINTER_ADDR, {r[8:0], ptrs[i]});
            spi_read(16, word);
            compare_data($sformatf("spi read @%02h", ptrs[i]), exp_regs[ptrs[i]], word);
        end
        // Released after 8 bits with a one still in the MSB of the shift register
        write_reg(SPI_POINTER_ADDR, 16'h0080);
        spi_read(8, word);
        compare_data("spi partial read", 16'h0000, word);
    endtask

    task automatic classify_keys();
        logic [31:0] r;
        logic        vld;
        logic        prev_valid;
        cls_result_t prev_exp;
        write_reg(TABLE_CTRL_ADDR, 16'h0002);
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            write_reg(reg_addr_t'('h30 + i), r[15:0]);
        end
        r = next_rand();
        write_reg(TABLE_HASH_ADDR, r[15:0]);
        write_reg(TABLE_CTRL_ADDR, 16'h0001);
        prev_valid = 1'b0;
        prev_exp   = '0;
        for (int i = 0; i < 24; i++) begin
            r   = next_rand();
            vld = (i < 8) ? 1'b1 : r[0];
            r   = next_rand();
            @(posedge clk);
            key_valid <= vld;
            key       <= r;
            @(negedge clk);
            compare_bit("classify valid", prev_valid, cls_valid);
            if (prev_valid) compare_cls("classify result", prev_exp, cls);
            if (vld) classified++;
            prev_valid = vld;
            prev_exp   = expected_cls(r);
        end
        @(posedge clk);
        key_valid <= 1'b0;
        @(negedge clk);
        compare_bit("classify valid", prev_valid, cls_valid);
        if (prev_valid) compare_cls("classify result", prev_exp, cls);
        @(posedge clk);
        @(negedge clk);
        compare_data("lookup count", reg_data_t'(classified), lookup_count);
    endtask

    task automatic disabled_update_and_clear();
        write_reg(TABLE_CTRL_ADDR, 16'h0000);
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            key_valid <= 1'b1;
            key       <= next_rand();
            @(negedge clk);
            compare_bit("valid with update off", 1'b0, cls_valid);
        end
        @(posedge clk);
        key_valid <= 1'b0;
        @(negedge clk);
        compare_bit("valid with update off", 1'b0, cls_valid);
        compare_data("count with update off", reg_data_t'(classified), lookup_count);
        write_reg(TABLE_CTRL_ADDR, 16'h0002);
        @(posedge clk);
        @(negedge clk);
        compare_data("count after clear", 16'h0000, lookup_count);
    endtask

    ////////////////////
    // Main sequence
    initial begin
        rst       = 1'b0;
        bus_addr  = '0;
        bus_wr    = 1'b0;
        bus_din   = '0;
        bus_raddr = '0;
        spi_cs_n  = 1'b1;
        spi_sclk  = 1'b0;
        key_valid = 1'b0;
        key       = '0;
        reset_model();
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        reset_values();
        write_readback();
        spi_pointer_reads();
        classify_keys();
        disabled_update_and_clear();
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: vlog.f
logic/switch_cfg_pkg.sv
logic/register_table.sv
logic/spi_readout.sv
logic/flow_classifier.sv
logic/switch_cfg_top.sv
tests/tb_switch_cfg.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_switch_cfg
FILELIST  := vlog.f
VFLAGS    := --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation result: pass" || \
		(echo "Simulation result: fail"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
